//--- src.f
+incdir+.
audioPkg.sv
audioBus.sv
cpuRegWriter.sv
sampleFetcher.sv
voiceChannel.sv
stereoMixer.sv
i2sSerializer.sv
audioSystem.sv
tbClock.sv
tbAudioSystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbAudioSystem
FLIST     ?= src.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

//--- tbAudioSystem.sv
/* Directed testbench for the audio engine. Memory halfwords hold their own
   byte address / 2 - 1000, so expected samples follow from the addresses.
   Tests align on the first audible I2S frame, not on cycle counts. */
`timescale 1ns/10ps
`default_nettype none

module tbAudioSystem;
    // About 60 frames of 256 cycles plus slack
    localparam int maxCycles = 40000;

    logic        aclk;
    logic        aresetn;
    logic [31:0] awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic        wValid;
    logic        wReady;
    logic        bValid;
    logic        bReady;
    logic [31:0] arAddr;
    logic        arValid;
    logic        arReady = 1'b0;
    logic [31:0] rData = '0;
    logic        rValid = 1'b0;
    logic        rReady;
    logic        bclk;
    logic        lrclk;
    logic        dout;

    tbClock i_tbClock (.o_aclk(aclk), .o_aresetn(aresetn));

    audioSystem i_audioSystem (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_awAddr     (awAddr),
        .i_awValid    (awValid),
        .o_awReady    (awReady),
        .i_wData      (wData),
        .i_wValid     (wValid),
        .o_wReady     (wReady),
        .o_bValid     (bValid),
        .i_bReady     (bReady),
        .o_arAddr     (arAddr),
        .o_arValid    (arValid),
        .i_arReady    (arReady),
        .i_rData      (rData),
        .i_rValid     (rValid),
        .o_rReady     (rReady),
        .o_audioBclk  (bclk),
        .o_audioLrclk (lrclk),
        .o_audioDout  (dout)
    );

    // ############################################################
    // Memory model, random ARREADY delay of 0 to 3 cycles
    int          seed = 72;
    int          memDelay = 0;
    int          memPhase = 0;
    int          readCount = 0;
    logic [31:0] memAddr = '0;

    function automatic logic [15:0] halfAt(input logic [31:0] byteAddr);
        return 16'((byteAddr >> 1) - 32'd1000);
    endfunction

    always @(negedge aclk) begin
        if (!aresetn) begin
            memPhase = 0;
            arReady  = 1'b0;
            rValid   = 1'b0;
        end else begin
            case (memPhase)
                0: if (arValid) begin
                    if (memDelay == 0) begin
                        arReady   = 1'b1;
                        memAddr   = arAddr;
                        readCount = readCount + 1;
                        memPhase  = 1;
                    end else begin
                        memDelay = memDelay - 1;
                    end
                end
                1: begin
                    // Address accepted, the fetcher must now wait for data
                    checkEq("memory rready", 1, rReady);
                    arReady  = 1'b0;
                    rValid   = 1'b1;
                    rData    = {halfAt(memAddr + 32'd2), halfAt(memAddr)};
                    memPhase = 2;
                end
                default: begin
                    rValid   = 1'b0;
                    memDelay = $unsigned($random(seed)) % 4;
                    memPhase = 0;
                end
            endcase
        end
    end

    // ############################################################
    // I2S receiver
    logic [31:0]        rxShift = '0;
    logic signed [15:0] rxLeft = '0;
    logic signed [15:0] rxRight = '0;
    logic               prevLr = 1'b0;
    int                 frameCount = 0;
    int                 runLen = 0;
    int                 halfLen = 0;
    int                 doutOnes = 0;

    always @(posedge bclk) begin
        rxShift = {rxShift[30:0], dout};
        if (dout) doutOnes = doutOnes + 1;
        if (lrclk != prevLr) begin
            halfLen = runLen;
            runLen  = 1;
            // Right LSB arrives just after lrclk falls
            if (!lrclk) begin
                rxLeft     = rxShift[31:16];
                rxRight    = rxShift[15:0];
                frameCount = frameCount + 1;
            end
        end else begin
            runLen = runLen + 1;
        end
        prevLr = lrclk;
    end

    int cycles = 0;

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= maxCycles) begin
            $display("Timeout: the run went past %0d clock cycles", maxCycles);
            $display("Test failures found");
            $fatal(1);
        end
    end

    // ############################################################
    // Helpers
    task automatic checkEq(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error [%s] expected %0d, actual %0d", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    function automatic int sampleAt(input logic [31:0] start, input int pos);
        logic signed [15:0] h;
        h = halfAt(start + 32'(2 * pos));
        return h;
    endfunction

    function automatic int contrib(input int s, input int vol);
        return (s * vol) >>> 7;
    endfunction

    function automatic int scaleOut(input int sum, input int gain);
        int v;
        v = (sum * gain) >>> 7;
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    task automatic writeReg(input audioPkg::regSel_e sel, input logic [31:0] data,
                            input bit holdResp);
        bit awHit;
        bit wHit;
        @(negedge aclk);
        awAddr  = {26'd0, sel, 2'b00};
        awValid = 1'b1;
        wData   = data;
        wValid  = 1'b1;
        bReady  = !holdResp;
        do begin
            awHit = awValid && awReady;
            wHit  = wValid && wReady;
            @(negedge aclk);
            if (awHit) awValid = 1'b0;
            if (wHit) wValid = 1'b0;
        end while (awValid || wValid);
        while (!bValid) @(negedge aclk);
    endtask

    task automatic waitFrame();
        int n;
        n = frameCount;
        while (frameCount == n) @(negedge aclk);
    endtask

    task automatic waitAudible();
        while (rxLeft == 0 && rxRight == 0) waitFrame();
    endtask

    task automatic setupVoice(input int mask, input logic [31:0] start, input int count,
                              input int loopS, input int loopE, input int vol,
                              input int ctrl);
        writeReg(audioPkg::selChanMask, mask, 0);
        writeReg(audioPkg::selStart, start, 0);
        writeReg(audioPkg::selCount, count, 0);
        writeReg(audioPkg::selLoopStart, loopS, 0);
        writeReg(audioPkg::selLoopEnd, loopE, 0);
        writeReg(audioPkg::selPosition, 0, 0);
        writeReg(audioPkg::selVolume, vol, 0);
        writeReg(audioPkg::selControl, ctrl, 0);
    endtask

    task automatic stopAll();
        writeReg(audioPkg::selChanMask, 8'hff, 0);
        writeReg(audioPkg::selControl, 0, 0);
        repeat (3) waitFrame();
    endtask

    localparam int play  = 1 << audioPkg::ctrlPlaying;
    localparam int loop  = 1 << audioPkg::ctrlLooping;
    localparam int mono  = 1 << audioPkg::ctrlMono;
    localparam int right = 1 << audioPkg::ctrlRight;

    // ############################################################
    // Tests
    task automatic testReset();
        int ones;
        ones = doutOnes;
        repeat (3) waitFrame();
        checkEq("reset dout", ones, doutOnes);
        checkEq("reset lrclk half", 16, halfLen);
        checkEq("reset reads", 0, readCount);
    endtask

    // Load that reaches count silences the voice, so count-1 samples are heard
    task automatic testMonoOneShot();
        int e;
        int reads;
        setupVoice(1, 32'h1000, 4, 0, 0, 128, play | mono);
        waitAudible();
        for (int k = 0; k < 3; k++) begin
            e = scaleOut(contrib(sampleAt(32'h1000, k), 128), 128);
            checkEq("mono left", e, rxLeft);
            checkEq("mono right", e, rxRight);
            waitFrame();
        end
        checkEq("mono silent", 0, rxLeft);
        reads = readCount;
        repeat (3) waitFrame();
        checkEq("mono no reads", reads, readCount);
        checkEq("mono still silent", 0, rxRight);
    endtask

    task automatic testRightPan();
        setupVoice(1, 32'h2000, 16, 0, 0, 64, play | right);
        waitAudible();
        for (int k = 0; k < 3; k++) begin
            checkEq("pan right", scaleOut(contrib(sampleAt(32'h2000, k), 64), 128), rxRight);
            checkEq("pan left", 0, rxLeft);
            waitFrame();
        end
        stopAll();
    endtask

    task automatic testLoop();
        int seq [8] = '{0, 1, 2, 3, 4, 2, 3, 4};
        setupVoice(1, 32'h3000, 8, 2, 5, 128, play | loop | mono);
        waitAudible();
        foreach (seq[k]) begin
            checkEq("loop", scaleOut(contrib(sampleAt(32'h3000, seq[k]), 128), 128), rxLeft);
            waitFrame();
        end
        stopAll();
    endtask

    task automatic testSaturate();
        // Samples near +30000 on the left pair, near -30000 on the right pair
        setupVoice(3, 32'hf230, 64, 0, 0, 255, play);
        setupVoice(12, 32'h11d70, 64, 0, 0, 255, play | right);
        while (rxLeft == 0 || rxRight == 0) waitFrame();
        repeat (2) begin
            checkEq("saturate left", 32767, rxLeft);
            checkEq("saturate right", -32768, rxRight);
            waitFrame();
        end
        stopAll();
        writeReg(audioPkg::selGlobalVol, 64, 0);
        setupVoice(1, 32'h1000, 32, 0, 0, 128, play | mono);
        waitAudible();
        for (int k = 0; k < 2; k++) begin
            checkEq("global half", scaleOut(contrib(sampleAt(32'h1000, k), 128), 64), rxLeft);
            waitFrame();
        end
        stopAll();
        writeReg(audioPkg::selGlobalVol, 128, 0);
    endtask

    task automatic testHeldResponse();
        int e;
        setupVoice(3, 32'h4000, 32, 0, 0, 128, 0);
        writeReg(audioPkg::selChanMask, 2, 0);
        writeReg(audioPkg::selVolume, 64, 1);
        repeat (8) begin
            @(negedge aclk);
            checkEq("bvalid held", 1, bValid);
        end
        bReady = 1'b1;
        @(negedge aclk);
        checkEq("bvalid released", 0, bValid);
        writeReg(audioPkg::selChanMask, 3, 0);
        writeReg(audioPkg::selControl, play | mono, 0);
        waitAudible();
        for (int k = 0; k < 3; k++) begin
            e = scaleOut(contrib(sampleAt(32'h4000, k), 128) +
                         contrib(sampleAt(32'h4000, k), 64), 128);
            checkEq("masked volume", e, rxLeft);
            waitFrame();
        end
        stopAll();
    endtask

    initial begin
        awAddr  = '0;
        awValid = 1'b0;
        wData   = '0;
        wValid  = 1'b0;
        bReady  = 1'b1;
        while (!aresetn) @(negedge aclk);
        testReset();
        testMonoOneShot();
        testRightPan();
        testLoop();
        testSaturate();
        testHeldResponse();
        $display("All tests passed!");
        $finish;
    end
endmodule

`default_nettype wire

//--- tbClock.sv
/* Testbench clock, 4 ns period. Reset is held low for 4 cycles and
   released on a falling edge. */
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic o_aclk,
    output logic o_aresetn
);
    initial begin
        o_aclk = 1'b0;
        forever #2 o_aclk = ~o_aclk;
    end

    initial begin
        o_aresetn = 1'b0;
        repeat (4) @(posedge o_aclk);
        @(negedge o_aclk);
        o_aresetn = 1'b1;
    end
endmodule

`default_nettype wire

//--- audioSystem.sv
/* Eight-voice sample playback engine, single aclk domain.
   CPU writes over AXI-Lite (no read-back), samples fetched over AXI-Lite. */
`timescale 1ns/10ps
`default_nettype none
`include "audioMix_consts.svh"

module audioSystem (
    input  wire                          aclk,
    input  wire                          aresetn,
    // ############################################################
    // CPU write port
    input  wire  [`AUDIO_ADDR_WIDTH-1:0] i_awAddr,
    input  wire                          i_awValid,
    output logic                         o_awReady,
    input  wire  [31:0]                  i_wData,
    input  wire                          i_wValid,
    output logic                         o_wReady,
    output logic                         o_bValid,
    input  wire                          i_bReady,
    // ############################################################
    // Sample memory read port
    output logic [`AUDIO_ADDR_WIDTH-1:0] o_arAddr,
    output logic                         o_arValid,
    input  wire                          i_arReady,
    input  wire  [31:0]                  i_rData,
    input  wire                          i_rValid,
    output logic                         o_rReady,
    // ############################################################
    // I2S out
    output logic                         o_audioBclk,
    output logic                         o_audioLrclk,
    output logic                         o_audioDout
);
    localparam int numChan = `AUDIO_NUM_CHANNELS;

    logic               mixStrobe;
    logic               frameStart;
    logic [7:0]         globalVolume;
    audioPkg::sample_t  mixLeft;
    audioPkg::sample_t  mixRight;

    cfgBus   cfg ();
    voiceBus voices [numChan] ();

    cpuRegWriter u_cpuRegWriter (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_awAddr       (i_awAddr),
        .i_awValid      (i_awValid),
        .o_awReady      (o_awReady),
        .i_wData        (i_wData),
        .i_wValid       (i_wValid),
        .o_wReady       (o_wReady),
        .o_bValid       (o_bValid),
        .i_bReady       (i_bReady),
        .o_globalVolume (globalVolume),
        .cfg            (cfg)
    );

    sampleFetcher u_sampleFetcher (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_frameStart (frameStart),
        .o_arAddr     (o_arAddr),
        .o_arValid    (o_arValid),
        .i_arReady    (i_arReady),
        .i_rData      (i_rData),
        .i_rValid     (i_rValid),
        .o_rReady     (o_rReady),
        .o_mixStrobe  (mixStrobe),
        .fetch        (voices)
    );

    for (genvar i = 0; i < numChan; i++) begin : gVoice
        voiceChannel #(.chanIndex(i)) u_voiceChannel (
            .aclk    (aclk),
            .aresetn (aresetn),
            .cfg     (cfg),
            .vb      (voices[i])
        );
    end

    stereoMixer u_stereoMixer (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_mixStrobe    (mixStrobe),
        .i_globalVolume (globalVolume),
        .mix            (voices),
        .o_left         (mixLeft),
        .o_right        (mixRight)
    );

    i2sSerializer u_i2sSerializer (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_left       (mixLeft),
        .i_right      (mixRight),
        .o_bclk       (o_audioBclk),
        .o_lrclk      (o_audioLrclk),
        .o_dout       (o_audioDout),
        .o_frameStart (frameStart)
    );

endmodule

`default_nettype wire

//--- i2sSerializer.sv
/* I2S transmitter, 16 bits per side, left while lrclk is low. bclk and lrclk
   are aclk registers, not clocks. The mix is sampled at each frame start. */
`timescale 1ns/10ps
`default_nettype none
`include "audioMix_consts.svh"

module i2sSerializer (
    input  wire                     aclk,
    input  wire                     aresetn,
    input  wire audioPkg::sample_t  i_left,
    input  wire audioPkg::sample_t  i_right,
    output logic                    o_bclk,
    output logic                    o_lrclk,
    output logic                    o_dout,
    output logic                    o_frameStart
);
    localparam int div = `AUDIO_BCLK_DIV;

    logic [7:0]  divCnt;
    logic [4:0]  bitCnt;
    logic [31:0] shiftReg;
    logic        tick;
    logic        fallEdge;
    logic        wrapEdge;

    assign tick     = (divCnt == 8'(div - 1));
    assign fallEdge = tick && o_bclk;
    assign wrapEdge = fallEdge && (bitCnt == 5'd31);
    assign o_lrclk  = bitCnt[4];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            divCnt       <= '0;
            o_bclk       <= 1'b0;
            bitCnt       <= 5'd31;
            o_frameStart <= 1'b0;
            o_dout       <= 1'b0;
            shiftReg     <= '0;
        end else begin
            o_frameStart <= wrapEdge;
            divCnt       <= tick ? '0 : divCnt + 1'b1;
            if (tick) begin
                o_bclk <= !o_bclk;
            end
            // Everything moves on the falling bclk edge
            if (fallEdge) begin
                bitCnt <= bitCnt + 1'b1;
                // dout lags the shift register by one bit, the I2S delay
                o_dout <= shiftReg[31];
                shiftReg <= wrapEdge ? {i_left, i_right} : {shiftReg[30:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- stereoMixer.sv
/* Sums the playing voices per side, applies the global volume and
   saturates. Output updates only on mixStrobe. */
`timescale 1ns/10ps
`default_nettype none
`include "audioMix_consts.svh"

module stereoMixer (
    input  wire                aclk,
    input  wire                aresetn,
    input  wire                i_mixStrobe,
    input  wire  [7:0]         i_globalVolume,
    voiceBus.mix               mix [`AUDIO_NUM_CHANNELS],
    output audioPkg::sample_t  o_left,
    output audioPkg::sample_t  o_right
);
    localparam int numChan = `AUDIO_NUM_CHANNELS;

    logic signed [31:0]  contrib [numChan];
    logic [numChan-1:0]  toLeft;
    logic [numChan-1:0]  toRight;
    logic signed [31:0]  leftSum;
    logic signed [31:0]  rightSum;

    // Gain of 128 is unity
    function automatic audioPkg::sample_t scaleSat(input logic signed [31:0] sum,
                                                   input logic [7:0] gain);
        logic signed [31:0] scaled;
        scaled = (sum * $signed({24'd0, gain})) >>> 7;
        if (scaled > 32'sd32767) begin
            return 16'sh7fff;
        end else if (scaled < -32'sd32768) begin
            return 16'sh8000;
        end
        return scaled[15:0];
    endfunction

    for (genvar i = 0; i < numChan; i++) begin : gChan
        assign contrib[i] = mix[i].playing
                          ? (32'(mix[i].outSample) * $signed({24'd0, mix[i].volume})) >>> 7
                          : 32'sd0;
        assign toLeft[i]  = mix[i].mono || !mix[i].right;
        assign toRight[i] = mix[i].mono || mix[i].right;
    end

    always_comb begin
        leftSum  = '0;
        rightSum = '0;
        for (int i = 0; i < numChan; i++) begin
            if (toLeft[i]) leftSum = leftSum + contrib[i];
            if (toRight[i]) rightSum = rightSum + contrib[i];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_left  <= '0;
            o_right <= '0;
        end else if (i_mixStrobe) begin
            o_left  <= scaleSat(leftSum, i_globalVolume);
            o_right <= scaleSat(rightSum, i_globalVolume);
        end
    end

endmodule

`default_nettype wire

//--- voiceChannel.sv
/* One playback voice. The load that brings a non-looping voice to its count
   stops it and silences it. Loop end is expected to be within count. */
`timescale 1ns/10ps
`default_nettype none
`include "audioMix_consts.svh"

module voiceChannel #(
    parameter int chanIndex = 0
) (
    input  wire     aclk,
    input  wire     aresetn,
    cfgBus.sink     cfg,
    voiceBus.voice  vb
);
    localparam int addrW = `AUDIO_ADDR_WIDTH;
    localparam int posW  = `AUDIO_POS_WIDTH;

    logic [addrW-1:0] startAddr;
    logic [posW-1:0]  count;
    logic [posW-1:0]  loopStart;
    logic [posW-1:0]  loopEnd;
    logic [posW-1:0]  position;
    logic [posW-1:0]  nextPos;
    logic [7:0]       volume;
    logic [3:0]       ctrl;
    logic             selected;
    logic             wrap;

    assign selected = cfg.wrEn && cfg.chanMask[chanIndex];
    assign nextPos  = position + 1'b1;
    assign wrap     = ctrl[audioPkg::ctrlLooping] && (nextPos == loopEnd || nextPos >= count);

    // Halfword samples, two bytes per position
    assign vb.addr    = startAddr + addrW'({position, 1'b0});
    assign vb.playing = ctrl[audioPkg::ctrlPlaying];
    assign vb.mono    = ctrl[audioPkg::ctrlMono];
    assign vb.right   = ctrl[audioPkg::ctrlRight];
    assign vb.volume  = volume;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ctrl         <= '0;
            position     <= '0;
            volume       <= 8'(`AUDIO_VOL_UNITY);
            vb.outSample <= '0;
        end else begin
            if (vb.load) begin
                vb.outSample <= vb.sample;
                if (wrap) begin
                    position <= loopStart;
                end else if (nextPos >= count) begin
                    ctrl[audioPkg::ctrlPlaying] <= 1'b0;
                    position                    <= '0;
                    vb.outSample                <= '0;
                end else begin
                    position <= nextPos;
                end
            end
            // CPU write wins over a load in the same cycle
            if (selected) begin
                case (cfg.regSel)
                    audioPkg::selPosition: position <= cfg.wrData[posW-1:0];
                    audioPkg::selVolume:   volume   <= cfg.wrData[7:0];
                    audioPkg::selControl:  ctrl     <= cfg.wrData[3:0];
                    default:               ctrl     <= ctrl;
                endcase
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (selected) begin
            case (cfg.regSel)
                audioPkg::selStart:     startAddr <= cfg.wrData[addrW-1:0];
                audioPkg::selCount:     count     <= cfg.wrData[posW-1:0];
                audioPkg::selLoopStart: loopStart <= cfg.wrData[posW-1:0];
                audioPkg::selLoopEnd:   loopEnd   <= cfg.wrData[posW-1:0];
                default:                startAddr <= startAddr;
            endcase
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn) vb.playing |-> position < count);

endmodule

`default_nettype wire

//--- sampleFetcher.sv
/* AXI-Lite read master, one read in flight. Walks channels 0 to N-1 after
   each frameStart; a frameStart during a walk is ignored. */
`timescale 1ns/10ps
`default_nettype none
`include "audioMix_consts.svh"

module sampleFetcher (
    input  wire                          aclk,
    input  wire                          aresetn,
    input  wire                          i_frameStart,
    output logic [`AUDIO_ADDR_WIDTH-1:0] o_arAddr,
    output logic                         o_arValid,
    input  wire                          i_arReady,
    input  wire  [31:0]                  i_rData,
    input  wire                          i_rValid,
    output logic                         o_rReady,
    output logic                         o_mixStrobe,
    voiceBus.fetch                       fetch [`AUDIO_NUM_CHANNELS]
);
    localparam int numChan = `AUDIO_NUM_CHANNELS;
    localparam int addrW   = `AUDIO_ADDR_WIDTH;
    localparam int idxW    = $clog2(numChan);

    typedef enum logic [2:0] {stIdle, stAddr, stData, stDeliver, stSkip} state_e;

    state_e               state;
    logic [idxW-1:0]      chan;
    logic [idxW-1:0]      nextChan;
    logic                 advance;
    logic                 halfSel;
    audioPkg::sample_t    sampleReg;
    logic [numChan-1:0]   playingVec;
    logic [numChan-1:0]   loadVec;
    logic [addrW-1:0]     addrArr [numChan];

    for (genvar i = 0; i < numChan; i++) begin : gVoice
        assign playingVec[i]   = fetch[i].playing;
        assign addrArr[i]      = fetch[i].addr;
        assign fetch[i].load   = loadVec[i];
        assign fetch[i].sample = sampleReg;
    end

    assign o_arValid = (state == stAddr);
    assign o_rReady  = (state == stData);
    assign loadVec   = (state == stDeliver) ? numChan'(1) << chan : '0;

    // Step to the next channel, or to channel 0 at frame start
    assign nextChan = (state == stIdle) ? '0 : chan + 1'b1;
    assign advance  = (state == stIdle && i_frameStart) ||
                      ((state == stDeliver || state == stSkip) && chan != idxW'(numChan - 1));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state       <= stIdle;
            chan        <= '0;
            o_mixStrobe <= 1'b0;
        end else begin
            o_mixStrobe <= 1'b0;
            if (advance) begin
                chan  <= nextChan;
                state <= playingVec[nextChan] ? stAddr : stSkip;
            end else begin
                case (state)
                    stAddr: if (i_arReady) state <= stData;
                    stData: if (i_rValid) state <= stDeliver;
                    stDeliver, stSkip: begin
                        // Last channel done
                        state       <= stIdle;
                        o_mixStrobe <= 1'b1;
                    end
                    default: state <= state;
                endcase
            end
        end
    end

    // Word aligned read, bit 1 picks the halfword (little-endian)
    always_ff @(posedge aclk) begin
        if (advance) begin
            o_arAddr <= {addrArr[nextChan][addrW-1:2], 2'b00};
            halfSel  <= addrArr[nextChan][1];
        end
        if (o_rReady && i_rValid) begin
            sampleReg <= halfSel ? i_rData[31:16] : i_rData[15:0];
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        o_arValid && !i_arReady |=> $stable(o_arAddr));
    assert property (@(posedge aclk) disable iff (!aresetn) $onehot0(loadVec));

endmodule

`default_nettype wire

//--- cpuRegWriter.sv
/* AXI-Lite write slave. Write strobes are ignored and every write ends OKAY.
   No new write completes while BVALID waits for BREADY. */
`timescale 1ns/10ps
`default_nettype none
`include "audioMix_consts.svh"

module cpuRegWriter (
    input  wire                          aclk,
    input  wire                          aresetn,
    input  wire  [`AUDIO_ADDR_WIDTH-1:0] i_awAddr,
    input  wire                          i_awValid,
    output logic                         o_awReady,
    input  wire  [31:0]                  i_wData,
    input  wire                          i_wValid,
    output logic                         o_wReady,
    output logic                         o_bValid,
    input  wire                          i_bReady,
    output logic [7:0]                   o_globalVolume,
    cfgBus.source                        cfg
);
    localparam int numChan = `AUDIO_NUM_CHANNELS;

    logic                 awPending;
    logic                 wPending;
    audioPkg::regSel_e    selReg;
    logic [31:0]          dataReg;
    logic [numChan-1:0]   chanMask;
    logic                 doWrite;
    logic                 localReg;

    assign o_awReady = !awPending;
    assign o_wReady  = !wPending;
    assign doWrite   = awPending && wPending && (!o_bValid || i_bReady);
    assign localReg  = (selReg == audioPkg::selGlobalVol) || (selReg == audioPkg::selChanMask);

    assign cfg.wrEn     = doWrite && !localReg;
    assign cfg.regSel   = selReg;
    assign cfg.wrData   = dataReg;
    assign cfg.chanMask = chanMask;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            awPending      <= 1'b0;
            wPending       <= 1'b0;
            o_bValid       <= 1'b0;
            chanMask       <= '0;
            o_globalVolume <= 8'(`AUDIO_VOL_UNITY);
        end else begin
            if (i_awValid && o_awReady) begin
                awPending <= 1'b1;
            end else if (doWrite) begin
                awPending <= 1'b0;
            end
            if (i_wValid && o_wReady) begin
                wPending <= 1'b1;
            end else if (doWrite) begin
                wPending <= 1'b0;
            end

            if (doWrite) begin
                o_bValid <= 1'b1;
            end else if (i_bReady) begin
                o_bValid <= 1'b0;
            end

            // Mask and global volume live here, not in the voices
            if (doWrite && selReg == audioPkg::selChanMask) begin
                chanMask <= dataReg[numChan-1:0];
            end
            if (doWrite && selReg == audioPkg::selGlobalVol) begin
                o_globalVolume <= dataReg[7:0];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (i_awValid && o_awReady) begin
            selReg <= audioPkg::regSel_e'(i_awAddr[5:2]);
        end
        if (i_wValid && o_wReady) begin
            dataReg <= i_wData;
        end
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        o_bValid && !i_bReady |=> o_bValid);

endmodule

`default_nettype wire

//--- audioBus.sv
/* Internal buses of the audio engine. voiceBus is instantiated once per
   channel, cfgBus once and shared by all voices. */
`timescale 1ns/10ps
`default_nettype none
`include "audioMix_consts.svh"

interface cfgBus;
    logic                             wrEn;
    audioPkg::regSel_e                regSel;
    logic [31:0]                      wrData;
    logic [`AUDIO_NUM_CHANNELS-1:0]   chanMask;

    modport source (output wrEn, output regSel, output wrData, output chanMask);
    modport sink   (input wrEn, input regSel, input wrData, input chanMask);
endinterface

interface voiceBus;
    logic                             load;
    audioPkg::sample_t                sample;
    logic [`AUDIO_ADDR_WIDTH-1:0]     addr;
    logic                             playing;
    logic                             mono;
    logic                             right;
    logic [7:0]                       volume;
    audioPkg::sample_t                outSample;

    modport voice (
        input  load, sample,
        output addr, playing, mono, right, volume, outSample
    );
    // Fetcher side, load is a single-cycle strobe
    modport fetch (output load, sample, input addr, playing);
    modport mix   (input outSample, mono, right, volume, playing);
endinterface

`default_nettype wire

//--- audioPkg.sv
/* Shared types of the audio engine. The register select is AWADDR[5:2]. */
`default_nettype none

package audioPkg;

    typedef enum logic [3:0] {
        selStart     = 4'd0,
        selCount     = 4'd1,
        selLoopStart = 4'd2,
        selLoopEnd   = 4'd3,
        selPosition  = 4'd4,
        selVolume    = 4'd5,
        selControl   = 4'd6,
        selGlobalVol = 4'd7,
        selChanMask  = 4'd8
    } regSel_e;

    typedef logic signed [15:0] sample_t;

    // Bits of the control register
    localparam int ctrlPlaying = 0;
    localparam int ctrlLooping = 1;
    localparam int ctrlMono    = 2;
    localparam int ctrlRight   = 3;

endpackage

`default_nettype wire

//--- audioMix_consts.svh
/* Sizing and reset constants for the audio engine.
   Changing AUDIO_NUM_CHANNELS also changes the channel mask width. */
`ifndef AUDIO_MIX_CONSTS_SVH
`define AUDIO_MIX_CONSTS_SVH

// Voices and bus widths
`define AUDIO_NUM_CHANNELS 8
`define AUDIO_ADDR_WIDTH   32
`define AUDIO_POS_WIDTH    16

// aclk cycles per half bit-clock period, one frame is 64 * this
`define AUDIO_BCLK_DIV     4

// Unity gain, also the reset value of every volume
`define AUDIO_VOL_UNITY    128

`endif
